// ==== src/fb_defines.svh ====
// size and address macros for the framebuffer video subsystem
// include wherever raster, fade or bus sizes are needed
`ifndef FB_DEFINES_SVH
`define FB_DEFINES_SVH

`define FB_WIDTH      16    // painted area
`define FB_HEIGHT     12
`define FB_PIXELS     192

`define H_ACTIVE      20    // horizontal raster in pixel clocks
`define H_TOTAL       28
`define H_SYNC_START  22
`define H_SYNC_END    24
`define V_ACTIVE      14    // vertical raster in lines
`define V_TOTAL       18
`define V_SYNC_START  15
`define V_SYNC_END    15

`define FADE_WAIT     2     // frames before the fade starts
`define FADE_RATE     4     // clocks per lfsr step
`define LFSR_SEED     8'h01

`define WB_ADR_W      9
`define WB_DAT_W      16
`define REG_CTRL      9'h110
`define REG_STATUS    9'h111
`define PAL_BASE      9'h100

`endif

// ==== src/fb_pkg.sv ====
// shared types for the framebuffer video subsystem
// imported by the interface and every design module

package fb_pkg;

    typedef logic signed [5:0] coord_t;   // screen coordinate
    typedef logic [7:0]        fb_addr_t; // framebuffer pixel address
    typedef logic [3:0]        cidx_t;    // palette colour index
    typedef logic [11:0]       rgb_t;     // 4 bits each of r, g, b
    typedef logic [7:0]        lfsr_t;

    // fizzlefade machine
    typedef enum logic [1:0] {
        FADE_IDLE,
        FADE_WAIT,
        FADE_RUN,
        FADE_DONE
    } fade_state_t;

endpackage

// ==== src/video_timing_if.sv ====
// raster timing bundle from the display timing generator
// source side drives, scanout and fade engine listen on the sink side
`timescale 1ns/10ps

interface video_timing_if import fb_pkg::*; ();

    coord_t sx;     // current column
    coord_t sy;     // current line
    logic   hsync;
    logic   vsync;
    logic   de;     // inside the active area
    logic   frame;  // first clock of a frame

    modport source (output sx, sy, hsync, vsync, de, frame);
    modport sink   (input  sx, sy, hsync, vsync, de, frame);

endinterface

// ==== src/display_timings.sv ====
// raster counters for the 28x18 display
// all outputs are registered and aligned with the coordinates
`timescale 1ns/10ps
`include "fb_defines.svh"

module display_timings import fb_pkg::*; (
    input  logic clk_pix,
    input  logic rst_n,
    video_timing_if.source vt
);

    coord_t x_nxt;
    coord_t y_nxt;

    // next position, wrapping at the raster totals
    always_comb begin
        if (vt.sx == coord_t'(`H_TOTAL - 1)) begin
            x_nxt = '0;
            if (vt.sy == coord_t'(`V_TOTAL - 1)) begin
                y_nxt = '0;
            end else begin
                y_nxt = vt.sy + coord_t'(1);
            end
        end else begin
            x_nxt = vt.sx + coord_t'(1);
            y_nxt = vt.sy;
        end
    end

    // start at the last raster position so the first clock after reset is the origin
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            vt.sx    <= coord_t'(`H_TOTAL - 1);
            vt.sy    <= coord_t'(`V_TOTAL - 1);
            vt.hsync <= 1'b0;
            vt.vsync <= 1'b0;
            vt.de    <= 1'b0;
            vt.frame <= 1'b0;
        end else begin
            vt.sx    <= x_nxt;
            vt.sy    <= y_nxt;
            vt.hsync <= (x_nxt >= `H_SYNC_START) && (x_nxt <= `H_SYNC_END);
            vt.vsync <= (y_nxt >= `V_SYNC_START) && (y_nxt <= `V_SYNC_END);
            vt.de    <= (x_nxt < `H_ACTIVE) && (y_nxt < `V_ACTIVE);
            vt.frame <= (x_nxt == 0) && (y_nxt == 0);
        end
    end

    a_frame_at_origin: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        vt.frame |-> (vt.sx == 0) && (vt.sy == 0)
    ) else $error("frame strobe away from the origin");

endmodule

// ==== src/fizzle_fade.sv ====
// fizzlefade engine, overwrites the framebuffer in lfsr order
// starts FADE_WAIT frames after fade_en rises and steps every FADE_RATE clocks
`timescale 1ns/10ps
`include "fb_defines.svh"

module fizzle_fade import fb_pkg::*; (
    input  logic     clk_pix,
    input  logic     rst_n,
    video_timing_if.sink vt,
    input  logic     fade_en,
    output logic     fade_we,
    output fb_addr_t fade_addr,
    output logic     fade_done
);

    localparam lfsr_t LFSR_TAPS = 8'hB8;  // x^8+x^6+x^5+x^4+1, maximal length
    localparam int    WAIT_W    = $clog2(`FADE_WAIT + 1);
    localparam int    RATE_W    = $clog2(`FADE_RATE);

    fade_state_t       state;
    lfsr_t             lfsr;
    lfsr_t             lfsr_nxt;
    lfsr_t             pix;        // lfsr state mapped onto 0..254
    logic [WAIT_W-1:0] frame_cnt;
    logic [RATE_W-1:0] rate_cnt;
    logic              step;

    assign lfsr_nxt  = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    assign pix       = lfsr - 1'b1;  // the lfsr never hits zero, so shift down to cover pixel 0
    assign step      = (state == FADE_RUN) && (rate_cnt == RATE_W'(`FADE_RATE - 1));
    assign fade_done = (state == FADE_DONE);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state     <= FADE_IDLE;
            lfsr      <= `LFSR_SEED;
            frame_cnt <= '0;
            rate_cnt  <= '0;
            fade_we   <= 1'b0;
        end else begin
            fade_we <= step && fade_en && (pix < `FB_PIXELS);  // off-screen states make no write
            if (!fade_en) begin
                state     <= FADE_IDLE;
                lfsr      <= `LFSR_SEED;
                frame_cnt <= '0;
                rate_cnt  <= '0;
            end else begin
                case (state)
                    FADE_IDLE: state <= FADE_WAIT;
                    FADE_WAIT: begin
                        if (vt.frame) begin
                            if (frame_cnt == WAIT_W'(`FADE_WAIT - 1)) begin
                                state <= FADE_RUN;
                            end else begin
                                frame_cnt <= frame_cnt + 1'b1;
                            end
                        end
                    end
                    FADE_RUN: begin
                        rate_cnt <= step ? '0 : rate_cnt + 1'b1;
                        if (step) begin
                            lfsr <= lfsr_nxt;
                            if (lfsr_nxt == `LFSR_SEED) begin
                                state <= FADE_DONE;  // full cycle of 255 states
                            end
                        end
                    end
                    default: ;  // FADE_DONE holds until fade_en drops
                endcase
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (step) begin
            fade_addr <= fb_addr_t'(pix);
        end
    end

    // fade_we is registered, so it follows a RUN cycle by one clock
    a_we_from_run: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        fade_we |-> $past(state) == FADE_RUN
    ) else $error("fade write issued outside FADE_RUN");

endmodule

// ==== src/fb_wb_regs.sv ====
// wishbone classic slave for palette, fade control and framebuffer writes
// fade writes take the framebuffer port first, a clashing host write waits a clock
`timescale 1ns/10ps
`include "fb_defines.svh"

module fb_wb_regs import fb_pkg::*; (
    input  logic                 clk_pix,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`WB_ADR_W-1:0] wb_adr,
    input  logic [`WB_DAT_W-1:0] wb_dat_w,
    output logic [`WB_DAT_W-1:0] wb_dat_r,
    output logic                 wb_ack,
    input  logic                 fade_we,
    input  fb_addr_t             fade_addr,
    input  logic                 fade_done,
    output logic                 fade_en,
    output logic                 fb_we,
    output fb_addr_t             fb_addr,
    output cidx_t                fb_cidx,
    input  cidx_t                pal_addr,
    output rgb_t                 pal_rgb
);

    rgb_t  pal [16];
    cidx_t fade_cidx;   // colour written by the fade
    logic  req;
    logic  hit_fb, hit_pal, hit_ctrl, hit_status;
    logic  host_fb_we;
    logic  collide;
    logic [`WB_DAT_W-1:0] rd_data;

    assign req        = wb_cyc && wb_stb && !wb_ack;  // a request is live until acked
    assign hit_fb     = wb_adr < `WB_ADR_W'(`FB_PIXELS);
    assign hit_pal    = {wb_adr[`WB_ADR_W-1:4], 4'h0} == `PAL_BASE;
    assign hit_ctrl   = wb_adr == `REG_CTRL;
    assign hit_status = wb_adr == `REG_STATUS;
    assign host_fb_we = req && wb_we && hit_fb;
    assign collide    = host_fb_we && fade_we;

    // framebuffer write port, fade first
    assign fb_we   = fade_we || host_fb_we;
    assign fb_addr = fade_we ? fade_addr : fb_addr_t'(wb_adr);
    assign fb_cidx = fade_we ? fade_cidx : cidx_t'(wb_dat_w);

    assign pal_rgb = pal[pal_addr];  // async lookup for scanout

    // framebuffer reads are not supported and return zero
    always_comb begin
        rd_data = '0;
        if (hit_pal) begin
            rd_data = `WB_DAT_W'(pal[wb_adr[3:0]]);
        end else if (hit_ctrl) begin
            rd_data = `WB_DAT_W'({fade_cidx, 3'b000, fade_en});
        end else if (hit_status) begin
            rd_data = `WB_DAT_W'(fade_done);
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            fade_en   <= 1'b0;
            fade_cidx <= '0;
        end else begin
            wb_ack <= req && !collide;  // a deferred write acks one clock later
            if (req && wb_we && hit_ctrl) begin
                fade_en   <= wb_dat_w[0];
                fade_cidx <= wb_dat_w[7:4];
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (req && wb_we && hit_pal) begin
            pal[wb_adr[3:0]] <= rgb_t'(wb_dat_w);
        end
        if (req) begin
            wb_dat_r <= rd_data;
        end
    end

    a_ack_single: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        wb_ack |=> !wb_ack
    ) else $error("wishbone ack held for two cycles");

endmodule

// ==== src/fb_scanout.sv ====
// framebuffer memory and scanout path through the palette
// colour, syncs and de leave three clocks after the coordinates
`timescale 1ns/10ps
`include "fb_defines.svh"

module fb_scanout import fb_pkg::*; (
    input  logic     clk_pix,
    input  logic     rst_n,
    video_timing_if.sink vt,
    input  logic     fb_we,
    input  fb_addr_t fb_addr,
    input  cidx_t    fb_cidx,
    output cidx_t    pal_addr,
    input  rgb_t     pal_rgb,
    output logic     hsync,
    output logic     vsync,
    output logic     de,
    output rgb_t     rgb
);

    cidx_t      fb_mem [`FB_PIXELS];
    fb_addr_t   rd_cnt;
    fb_addr_t   rd_addr;
    cidx_t      mem_cidx;
    logic       paint;
    // first two stages of the delay lines, the output registers are the third
    logic [1:0] paint_sr;
    logic [1:0] hs_sr;
    logic [1:0] vs_sr;
    logic [1:0] de_sr;

    assign paint = (vt.sx >= 0) && (vt.sx < `FB_WIDTH) &&
                   (vt.sy >= 0) && (vt.sy < `FB_HEIGHT);

    // frame falls on pixel 0, so the address restarts in the same clock
    assign rd_addr = vt.frame ? '0 : rd_cnt;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt <= '0;
        end else if (paint) begin
            rd_cnt <= rd_addr + 1'b1;
        end else begin
            rd_cnt <= rd_addr;
        end
    end

    // simple dual-port memory, then the palette register
    always_ff @(posedge clk_pix) begin
        if (fb_we) begin
            fb_mem[fb_addr] <= fb_cidx;
        end
        if (paint) begin
            mem_cidx <= fb_mem[rd_addr];
        end
        pal_addr <= mem_cidx;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            paint_sr <= '0;
            hs_sr    <= '0;
            vs_sr    <= '0;
            de_sr    <= '0;
            hsync    <= 1'b0;
            vsync    <= 1'b0;
            de       <= 1'b0;
            rgb      <= '0;
        end else begin
            paint_sr <= {paint_sr[0], paint};
            hs_sr    <= {hs_sr[0], vt.hsync};
            vs_sr    <= {vs_sr[0], vt.vsync};
            de_sr    <= {de_sr[0], vt.de};
            hsync    <= hs_sr[1];
            vsync    <= vs_sr[1];
            de       <= de_sr[1];
            rgb      <= paint_sr[1] ? pal_rgb : '0;  // black outside the painted area
        end
    end

endmodule

// ==== src/fb_display_top.sv ====
// top level of the framebuffer video subsystem
// host access over wishbone classic, video out as rgb with syncs and de
`timescale 1ns/10ps
`include "fb_defines.svh"

module fb_display_top import fb_pkg::*; (
    input  logic                 clk_pix,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`WB_ADR_W-1:0] wb_adr,
    input  logic [`WB_DAT_W-1:0] wb_dat_w,
    output logic [`WB_DAT_W-1:0] wb_dat_r,
    output logic                 wb_ack,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 de,
    output rgb_t                 rgb
);

    logic     fade_en;
    logic     fade_we;
    fb_addr_t fade_addr;
    logic     fade_done;
    logic     fb_we;       // merged host and fade write
    fb_addr_t fb_addr;
    cidx_t    fb_cidx;
    cidx_t    pal_addr;
    rgb_t     pal_rgb;

    video_timing_if vt ();

    display_timings u_timings (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .vt      (vt.source)
    );

    fizzle_fade u_fade (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .vt        (vt.sink),
        .fade_en   (fade_en),
        .fade_we   (fade_we),
        .fade_addr (fade_addr),
        .fade_done (fade_done)
    );

    fb_wb_regs u_regs (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .fade_we   (fade_we),
        .fade_addr (fade_addr),
        .fade_done (fade_done),
        .fade_en   (fade_en),
        .fb_we     (fb_we),
        .fb_addr   (fb_addr),
        .fb_cidx   (fb_cidx),
        .pal_addr  (pal_addr),
        .pal_rgb   (pal_rgb)
    );

    fb_scanout u_scanout (
        .clk_pix  (clk_pix),
        .rst_n    (rst_n),
        .vt       (vt.sink),
        .fb_we    (fb_we),
        .fb_addr  (fb_addr),
        .fb_cidx  (fb_cidx),
        .pal_addr (pal_addr),
        .pal_rgb  (pal_rgb),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .rgb      (rgb)
    );

endmodule

// ==== tb/tb_fb_display.sv ====
// testbench for the framebuffer video subsystem
// fills image and palette with random data and then replays tb/fb_display_trace.txt
`timescale 1ns/10ps
`include "fb_defines.svh"

module tb_fb_display import fb_pkg::*; ();

    localparam int FRAME_CYC = `H_TOTAL * `V_TOTAL;
    localparam int MAX_REC   = 64;

    logic                 clk_pix;
    logic                 rst_n;
    logic                 wb_cyc, wb_stb, wb_we;
    logic [`WB_ADR_W-1:0] wb_adr;
    logic [`WB_DAT_W-1:0] wb_dat_w;
    logic [`WB_DAT_W-1:0] wb_dat_r;
    logic                 wb_ack;
    logic                 hsync, vsync, de;
    rgb_t                 rgb;

    cidx_t fb_model [`FB_PIXELS];  // expected image
    rgb_t  pal_model [16];
    int    errors;
    int    checks;
    logic  check_en;               // compare pixels of the current frame
    int    pix_seen;
    logic  trace_ready;
    int    limit_cyc;
    event  vs_rise;
    int    px, py, runs, cyc_cnt, last_vs, vs_cnt, hs_cnt;
    logic  de_d, vs_d, hs_d;
    rgb_t  exp_rgb;

    fb_display_top u_dut (
        .clk_pix  (clk_pix),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .rgb      (rgb)
    );

    initial begin
        clk_pix = 1'b0;
        forever #20 clk_pix = ~clk_pix;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one classic cycle with the inputs held until ack
    task automatic bus_access(input logic we, input logic [`WB_ADR_W-1:0] adr,
                              input logic [`WB_DAT_W-1:0] dat,
                              output logic [`WB_DAT_W-1:0] rdat);
        int wait_cyc;
        wait_cyc = 0;
        @(posedge clk_pix);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        do begin
            @(posedge clk_pix);
            #1;
            wait_cyc++;
        end while (!wb_ack && wait_cyc < 16);
        if (!wb_ack) begin
            errors++;
            $display("no wishbone ack for address %h within 16 clocks", adr);
        end
        rdat = wb_dat_r;
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // expected effect of a host write
    task automatic model_write(input logic [`WB_ADR_W-1:0] adr, input logic [`WB_DAT_W-1:0] dat);
        int i;
        if (adr < `FB_PIXELS) begin
            fb_model[adr] = dat[3:0];
        end else if ((adr & 9'h1f0) == `PAL_BASE) begin
            pal_model[adr[3:0]] = dat[11:0];
        end else if (adr == `REG_CTRL && dat[0]) begin
            for (i = 0; i < `FB_PIXELS; i++) begin
                fb_model[i] = dat[7:4];  // a finished fade covers every pixel
            end
        end
    endtask

    // full active frame between two vsync pulses
    task automatic check_frame();
        @(vs_rise);
        pix_seen = 0;
        check_en = 1'b1;
        @(vs_rise);
        check_en = 1'b0;
        if (pix_seen != `H_ACTIVE * `V_ACTIVE) begin
            errors++;
            $display("frame check saw %0d active pixels instead of %0d", pix_seen,
                     `H_ACTIVE * `V_ACTIVE);
        end
    endtask

    // pixel checker on the falling edge where the registered outputs are settled
    always @(negedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            px      = 0;
            py      = 0;
            runs    = 0;
            cyc_cnt = 0;
            last_vs = 0;
            vs_cnt  = 0;
            hs_cnt  = 0;
            de_d    = 1'b0;
            vs_d    = 1'b0;
            hs_d    = 1'b0;
        end else begin
            cyc_cnt++;
            if (hsync && de) begin
                errors++;
                $display("hsync high inside the active area at line %0d", py);
            end
            if (hsync && !hs_d) begin
                hs_cnt++;  // one pulse per raster line
            end
            if (de) begin
                exp_rgb = (px < `FB_WIDTH && py < `FB_HEIGHT) ?
                          pal_model[fb_model[py * `FB_WIDTH + px]] : 12'h000;
                if (check_en) begin
                    checks++;
                    pix_seen++;
                    if (rgb !== exp_rgb) begin
                        errors++;
                        $display("CHECK FAILED rgb at x=%0d y=%0d got %h expected %h",
                                 px, py, rgb, exp_rgb);
                    end
                end
                px++;
            end else if (de_d) begin
                if (px != `H_ACTIVE) begin
                    errors++;
                    $display("de run of %0d pixels on line %0d", px, py);
                end
                runs++;
                py++;
                px = 0;
            end
            if (vsync && !vs_d) begin
                if (runs != `V_ACTIVE) begin
                    errors++;
                    $display("frame had %0d de runs instead of %0d", runs, `V_ACTIVE);
                end
                if (vs_cnt > 0 && cyc_cnt - last_vs != FRAME_CYC) begin
                    errors++;
                    $display("vsync came %0d clocks after the last one", cyc_cnt - last_vs);
                end
                if (vs_cnt > 0 && hs_cnt != `V_TOTAL) begin
                    errors++;
                    $display("frame had %0d hsync pulses instead of %0d", hs_cnt, `V_TOTAL);
                end
                vs_cnt++;
                last_vs = cyc_cnt;
                runs    = 0;
                py      = 0;
                hs_cnt  = 0;
                -> vs_rise;
            end
            de_d = de;
            vs_d = vsync;
            hs_d = hsync;
        end
    end

    initial begin : main
        int                   fd, n, nrec, frames, i;
        logic [7:0]           op;
        logic [31:0]          a, d, seed;
        logic [8*128-1:0]     junk;
        logic [7:0]           tr_op [MAX_REC];
        logic [31:0]          tr_a [MAX_REC];
        logic [31:0]          tr_d [MAX_REC];
        logic [`WB_DAT_W-1:0] rdat;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        rst_n       = 1'b0;
        check_en    = 1'b0;
        errors      = 0;
        checks      = 0;
        pix_seen    = 0;
        trace_ready = 1'b0;
        nrec        = 0;
        frames      = 0;
        fd = $fopen("tb/fb_display_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the trace file tb/fb_display_trace.txt");
        end
        while (fd != 0 && !$feof(fd) && nrec < MAX_REC) begin
            n = $fscanf(fd, " %c", op);
            if (n != 1) begin
                break;
            end
            if (op == "#") begin
                n = $fgets(junk, fd);  // comment line
            end else begin
                a = 0;
                d = 0;
                if (op == "W" || op == "R") begin
                    n = $fscanf(fd, " %h %h", a, d);
                end else if (op == "F") begin
                    n = $fscanf(fd, " %d", a);
                end
                tr_op[nrec] = op;
                tr_a[nrec]  = a;
                tr_d[nrec]  = d;
                nrec++;
                frames += (op == "F") ? int'(a) : (op == "P") ? 2 : 0;
            end
        end
        limit_cyc   = (frames + 10) * FRAME_CYC;
        trace_ready = 1'b1;

        repeat (8) @(posedge clk_pix);
        #2;
        rst_n = 1'b1;

        // random palette first and the image after it
        seed = 32'h3034;
        for (i = 0; i < 16 + `FB_PIXELS; i++) begin
            seed = xorshift(seed);
            a    = (i < 16) ? `PAL_BASE + i : i - 16;
            d    = (i < 16) ? {20'h0, seed[11:0]} : {28'h0, seed[3:0]};
            bus_access(1'b1, a[8:0], d[15:0], rdat);
            model_write(a[8:0], d[15:0]);
        end

        for (i = 0; i < nrec; i++) begin
            case (tr_op[i])
                "W": begin
                    bus_access(1'b1, tr_a[i][8:0], tr_d[i][15:0], rdat);
                    model_write(tr_a[i][8:0], tr_d[i][15:0]);
                end
                "R": begin
                    bus_access(1'b0, tr_a[i][8:0], 16'h0, rdat);
                    checks++;
                    if (rdat !== tr_d[i][15:0]) begin
                        errors++;
                        $display("CHECK FAILED wb_dat_r at %h got %h expected %h",
                                 tr_a[i][8:0], rdat, tr_d[i][15:0]);
                    end
                end
                "F": repeat (tr_a[i]) @(vs_rise);
                "P": check_frame();
                default: begin
                    errors++;
                    $display("unknown trace record %c", tr_op[i]);
                end
            endcase
        end

        repeat (4) @(posedge clk_pix);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $display("errors: %0d  checks: %0d", errors, checks);
        $finish;
    end

    initial begin : watchdog
        wait (trace_ready);
        repeat (limit_cyc) @(posedge clk_pix);
        $display("timeout, the run did not finish within %0d clocks", limit_cyc);
        $display("TB FAILED");
        $display("errors: %0d  checks: %0d", errors, checks);
        $finish;
    end

endmodule

// ==== tb/fb_display_trace.txt ====
# op addr data: W write, R read and compare, F wait n frames, P check one frame
# addr and data in hex, frame count in decimal
R 110 0000
R 111 0000
R 005 0000
W 105 0abc
R 105 0abc
W 10e 0f00
R 10e 0f00
P
F 1
# palette update
W 103 0123
P
# fade with colour 9, host writes while it runs
W 110 0091
F 2
W 010 0009
W 011 0009
W 0a5 0009
W 0bf 0009
F 4
R 111 0001
R 110 0091
P
# fade cleared, host writes land again
W 110 0000
R 111 0000
W 000 0003
W 021 000c
W 0bf 0005
P

// ==== fb_display.f ====
+incdir+src
src/fb_pkg.sv
src/video_timing_if.sv
src/display_timings.sv
src/fizzle_fade.sv
src/fb_wb_regs.sv
src/fb_scanout.sv
src/fb_display_top.sv
tb/tb_fb_display.sv

// ==== Bender.yml ====
package:
  name: fb_display

sources:
  - include_dirs:
      - src
    files:
      - src/fb_pkg.sv
      - src/video_timing_if.sv
      - src/display_timings.sv
      - src/fizzle_fade.sv
      - src/fb_wb_regs.sv
      - src/fb_scanout.sv
      - src/fb_display_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_fb_display.sv
